// File: tests/quick_spi_vectors.txt
# cpol cpha burst read slave out_bits elems in_bits out_data miso_pattern expected_rx
# All columns hex; out_bits, elems and in_bits are counts, data fields are LSB first.
0 0 0 0 0 8 1 0 00000000000000A5 0000000000000000 0000000000000000
0 1 0 0 1 10 1 0 000000000000C3E1 0000000000000000 0000000000000000
1 0 0 1 0 8 1 8 000000000000005A 123456789ABCDE3C 000000000000003C
1 1 1 0 1 8 3 0 00000000003C96F0 0000000000000000 0000000000000000
0 0 1 1 1 C 2 4 0000000000ABC123 FEDCBA9876543210 0000000000000010
1 1 1 1 0 8 4 8 00000000DEADBEEF 0F1E2D3C4B5A6978 000000004B5A6978
0 1 1 1 0 10 2 C 0000000012345678 13579BDF2468ACE0 000000000068ACE0
1 0 0 1 1 5 1 3 0000000000000017 00000000000000A5 0000000000000005
0 0 1 0 0 8 1 0 0000000000000081 0000000000000000 0000000000000000

// File: files.f
+incdir+design
design/quick_spi_pkg.sv
design/axi_write_slave.sv
design/axi_read_slave.sv
design/spi_buffer_ram.sv
design/spi_transfer_engine.sv
design/quick_spi.sv
tests/quick_spi_checker.sv
tests/quick_spi_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the quick_spi testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module quick_spi_tb \
    -f files.f -o quick_spi_sim
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

output=$(./obj_dir/quick_spi_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "All tests passed!"; then
    exit 0
fi
exit 1

// File: tests/quick_spi_tb.sv
`timescale 1ns/1ps
`include "quick_spi_config.svh"

module quick_spi_tb;
    import quick_spi_pkg::*;

    localparam int MAX_VEC = 16;

    logic s_axi_aclk = 1'b0;
    logic s_axi_aresetn;
    axi_addr_t awaddr;
    axi_len_t awlen;
    logic [1:0] awburst;
    logic awvalid;
    logic awready;
    axi_data_t wdata;
    axi_strb_t wstrb;
    logic wlast;
    logic wvalid;
    logic wready;
    logic [1:0] bresp;
    logic bvalid;
    logic bready;
    axi_addr_t araddr;
    axi_len_t arlen;
    logic [1:0] arburst;
    logic arvalid;
    logic arready;
    axi_data_t rdata;
    logic [1:0] rresp;
    logic rlast;
    logic rvalid;
    logic rready;
    logic mosi;
    logic miso = 1'b0;
    logic sclk;
    logic [`QSPI_NUM_SLAVES-1:0] ss_n;
    logic interrupt;

    logic [63:0] vec [MAX_VEC][11];
    int n_vec = 0;
    int limit = 1000000;
    int cycles = 0;
    int tests = 0;
    int failed = 0;
    logic [31:0] rng = 32'he833;
    axi_data_t wr_q[$];
    axi_strb_t strb_q[$];
    axi_data_t rd_q[$];

    // SPI slave model state.
    logic cur_cpol = 1'b0;
    logic cur_cpha = 1'b0;
    int cur_slave = 0;
    int cur_out_bits = 0;
    logic [63:0] cur_pat = '0;
    int in_cnt = 0;
    int in_edges = 0;
    logic sclk_q = 1'b0;
    logic sel_q = 1'b0;

    quick_spi u_dut (.*);

    quick_spi_checker u_chk (.s_axi_aclk, .sclk, .mosi, .ss_n, .interrupt);

    always #20 s_axi_aclk = ~s_axi_aclk;

    always @(posedge s_axi_aclk) begin
        cycles++;
        if (cycles > limit) begin
            $display("Timeout: no progress within %0d cycles", limit);
            $display("Test failures found");
            $finish;
        end
    end

    // Slave shifts the pattern out, changing miso between sample edges.
    always @(negedge s_axi_aclk) begin
        logic sel;
        sel = !ss_n[cur_slave];
        if (sel_q && sclk != sclk_q && ((sclk_q == cur_cpol) != cur_cpha)) begin
            if (in_edges >= cur_out_bits) begin
                in_cnt++;
            end
            in_edges++;
        end
        if (sel_q && !sel) begin
            in_edges = 0;
        end
        miso = cur_pat[in_cnt % 64];
        sclk_q = sclk;
        sel_q = sel;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    task automatic axi_write(input axi_addr_t addr, input logic [1:0] burst);
        int n;
        n = wr_q.size();
        awaddr = addr;
        awlen = axi_len_t'(n - 1);
        awburst = burst;
        awvalid = 1'b1;
        do @(posedge s_axi_aclk); while (!awready);
        #2;
        awvalid = 1'b0;
        for (int i = 0; i < n; i++) begin
            wdata = wr_q[i];
            wstrb = strb_q[i];
            wlast = (i == n - 1);
            wvalid = 1'b1;
            do @(posedge s_axi_aclk); while (!wready);
            #2;
        end
        wvalid = 1'b0;
        wlast = 1'b0;
        bready = 1'b1;
        do @(posedge s_axi_aclk); while (!bvalid);
        u_chk.check_eq("bresp", bresp, `QSPI_RESP_OKAY);
        #2;
        bready = 1'b0;
        wr_q.delete();
        strb_q.delete();
    endtask

    task automatic axi_read(input axi_addr_t addr, input int n, input logic [1:0] burst);
        rd_q.delete();
        araddr = addr;
        arlen = axi_len_t'(n - 1);
        arburst = burst;
        arvalid = 1'b1;
        do @(posedge s_axi_aclk); while (!arready);
        #2;
        arvalid = 1'b0;
        rready = 1'b1;
        for (int i = 0; i < n; i++) begin
            do @(posedge s_axi_aclk); while (!rvalid);
            rd_q.push_back(rdata);
            u_chk.check_eq($sformatf("rlast beat %0d", i), rlast, i == n - 1);
            u_chk.check_eq("rresp", rresp, `QSPI_RESP_OKAY);
        end
        #2;
        rready = 1'b0;
    endtask

    task automatic push_word(input axi_data_t data, input axi_strb_t strb);
        wr_q.push_back(data);
        strb_q.push_back(strb);
    endtask

    task automatic report(input string name, input int err_before);
        tests++;
        if (u_chk.errors != err_before) begin
            failed++;
            $display("test %0d %s: failed", tests, name);
        end else begin
            $display("test %0d %s: passed", tests, name);
        end
    endtask

    task automatic run_incr_test();
        axi_data_t exp_words[16];
        int err0;
        err0 = u_chk.errors;
        for (int i = 0; i < 16; i++) begin
            rng = xorshift(rng);
            // Start bit kept clear so no transfer begins.
            exp_words[i] = (i == 0) ? (rng & ~32'h4) : rng;
            push_word(exp_words[i], 4'hf);
        end
        axi_write(8'h00, `QSPI_BURST_INCR);
        axi_read(8'h00, 16, `QSPI_BURST_INCR);
        for (int i = 0; i < 16; i++) begin
            u_chk.check_eq($sformatf("rdata word %0d", i), rd_q[i], exp_words[i]);
        end
        report("incr burst", err0);
    endtask

    task automatic run_strobe_test();
        axi_data_t last;
        int err0;
        err0 = u_chk.errors;
        push_word(32'h11223344, 4'hf);
        axi_write(8'h08, `QSPI_BURST_INCR);
        push_word(32'haabbccdd, 4'b0101);
        axi_write(8'h08, `QSPI_BURST_INCR);
        axi_read(8'h08, 1, `QSPI_BURST_INCR);
        u_chk.check_eq("rdata strobed", rd_q[0], 32'h11bb33dd);
        for (int i = 0; i < 4; i++) begin
            rng = xorshift(rng);
            last = rng;
            push_word(last, 4'hf);
        end
        axi_write(8'h08, 2'b00);
        axi_read(8'h08, 2, 2'b00);
        u_chk.check_eq("rdata fixed beat 0", rd_q[0], last);
        u_chk.check_eq("rdata fixed beat 1", rd_q[1], last);
        report("strobes and fixed burst", err0);
    endtask

    task automatic run_vector(input int v);
        logic [7:0] ctrl;
        logic [95:0] rx_words;
        int frames;
        int err0;
        err0 = u_chk.errors;
        ctrl = {3'b000, vec[v][3][0], vec[v][2][0], 1'b0, vec[v][1][0], vec[v][0][0]};
        frames = vec[v][2][0] ? int'(vec[v][6]) : 1;
        for (int i = 0; i < 7; i++) begin
            push_word(32'h0, 4'hf);
        end
        axi_write(8'd36, `QSPI_BURST_INCR);
        push_word(vec[v][8][31:0], 4'hf);
        push_word(vec[v][8][63:32], 4'hf);
        axi_write(8'(`QSPI_WBUF_START), `QSPI_BURST_INCR);
        push_word({vec[v][5][15:0], vec[v][4][7:0], ctrl}, 4'hf);
        push_word({vec[v][7][15:0], vec[v][6][15:0]}, 4'hf);
        axi_write(8'h00, `QSPI_BURST_INCR);
        cur_cpol = vec[v][0][0];
        cur_cpha = vec[v][1][0];
        cur_slave = int'(vec[v][4]);
        cur_out_bits = int'(vec[v][5]);
        cur_pat = vec[v][9];
        in_cnt = 0;
        in_edges = 0;
        u_chk.arm(cur_cpol, cur_cpha, cur_slave, cur_out_bits, frames, vec[v][8]);
        push_word({24'h0, ctrl | 8'h04}, 4'b0001);
        axi_write(8'h00, `QSPI_BURST_INCR);
        while (interrupt) @(posedge s_axi_aclk);
        while (!interrupt) @(posedge s_axi_aclk);
        #2;
        u_chk.disarm();
        axi_read(8'h00, 1, `QSPI_BURST_INCR);
        u_chk.check_eq("control byte", rd_q[0][7:0], ctrl);
        axi_read(8'd36, 3, `QSPI_BURST_INCR);
        rx_words = {rd_q[2], rd_q[1], rd_q[0]};
        u_chk.check_eq("read buffer", rx_words[79:16], vec[v][10]);
        report($sformatf("spi vector %0d", v), err0);
    endtask

    initial begin
        int fd;
        string line;
        logic [63:0] f [11];
        s_axi_aresetn = 1'b0;
        awaddr = '0;
        awlen = '0;
        awburst = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wlast = 1'b0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arlen = '0;
        arburst = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        fd = $fopen("tests/quick_spi_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file tests/quick_spi_vectors.txt");
            $display("Test failures found");
            $finish;
        end else begin
            while (!$feof(fd) && n_vec < MAX_VEC) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#") begin
                    if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                                f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]) == 11) begin
                        vec[n_vec] = f;
                        n_vec++;
                    end
                end
            end
            $fclose(fd);
            // Room for the register tests, then each transfer by its length.
            limit = 600;
            for (int v = 0; v < n_vec; v++) begin
                limit += 2 * ((int'(vec[v][5]) + (vec[v][3][0] ? int'(vec[v][7]) : 0))
                         * (vec[v][2][0] ? int'(vec[v][6]) : 1) + 8) + 200;
            end
            repeat (3) @(posedge s_axi_aclk);
            #2;
            s_axi_aresetn = 1'b1;
            u_chk.check_eq("ss_n after reset", ss_n, {`QSPI_NUM_SLAVES{1'b1}});
            u_chk.check_eq("sclk after reset", sclk, 1'b0);
            u_chk.check_eq("mosi after reset", mosi, 1'b0);
            u_chk.check_eq("interrupt after reset", interrupt, 1'b0);
            u_chk.check_eq("bvalid after reset", bvalid, 1'b0);
            u_chk.check_eq("rvalid after reset", rvalid, 1'b0);
            u_chk.check_eq("awready after reset", awready, 1'b0);
            u_chk.check_eq("wready after reset", wready, 1'b0);
            u_chk.check_eq("arready after reset", arready, 1'b0);
            u_chk.check_eq("rlast after reset", rlast, 1'b0);
            run_incr_test();
            run_strobe_test();
            for (int v = 0; v < n_vec; v++) begin
                run_vector(v);
            end
            $display("%0d tests run, %0d failed, %0d check errors", tests, failed, u_chk.errors);
            if (u_chk.errors == 0 && n_vec > 0) begin
                $display("All tests passed!");
            end else begin
                $display("Test failures found");
            end
            $finish;
        end
    end

endmodule

// File: tests/quick_spi_checker.sv
`timescale 1ns/1ps
`include "quick_spi_config.svh"

module quick_spi_checker (
    input logic                        s_axi_aclk,
    input logic                        sclk,
    input logic                        mosi,
    input logic [`QSPI_NUM_SLAVES-1:0] ss_n,
    input logic                        interrupt
);
    int          errors = 0;
    logic        armed = 1'b0;
    logic        exp_cpol;
    logic        exp_cpha;
    int          exp_slave;
    int          exp_bits;
    int          exp_frames;
    logic [63:0] exp_out;
    int          frame_edges;
    int          out_cnt;
    int          frames;
    logic        sclk_q = 1'b0;
    logic        mosi_q = 1'b0;
    logic        sel_q = 1'b0;
    logic        irq_q = 1'b0;

    task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns %s: got %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic arm(input logic cpol, input logic cpha, input int slave, input int bits,
                       input int nframes, input logic [63:0] data);
        exp_cpol = cpol;
        exp_cpha = cpha;
        exp_slave = slave;
        exp_bits = bits;
        exp_frames = nframes;
        exp_out = data;
        frame_edges = 0;
        out_cnt = 0;
        frames = 0;
        armed = 1'b1;
    endtask

    task automatic disarm();
        armed = 1'b0;
    endtask

    // Pins settle after the rising edge, so look at them mid-cycle.
    always @(negedge s_axi_aclk) begin
        logic                        sel;
        logic [`QSPI_NUM_SLAVES-1:0] exp_ss;
        sel = !ss_n[exp_slave];
        exp_ss = '1;
        exp_ss[exp_slave] = 1'b0;
        if (armed) begin
            if (ss_n != '1) begin
                check_eq("ss_n", ss_n, exp_ss);
            end else begin
                check_eq("sclk", sclk, exp_cpol);
                check_eq("mosi idle", mosi, 1'b0);
            end
            // Sample edge is leading for CPHA 0, trailing for CPHA 1.
            if (sel_q && sclk != sclk_q && ((sclk_q == exp_cpol) != exp_cpha)) begin
                if (frame_edges < exp_bits) begin
                    check_eq($sformatf("mosi bit %0d", out_cnt), mosi_q, exp_out[out_cnt]);
                    out_cnt++;
                end
                frame_edges++;
            end
            if (sel_q && !sel) begin
                frames++;
                frame_edges = 0;
            end
            if (interrupt && !irq_q) begin
                check_eq("ss_n rises", frames, exp_frames);
                check_eq("mosi bit count", out_cnt, exp_bits * exp_frames);
            end
        end
        sclk_q = sclk;
        mosi_q = mosi;
        sel_q = sel;
        irq_q = interrupt;
    end

endmodule

// File: design/quick_spi.sv
`timescale 1ns/1ps
`include "quick_spi_config.svh"

module quick_spi (
    input  logic                         s_axi_aclk,
    input  logic                         s_axi_aresetn,
    input  quick_spi_pkg::axi_addr_t     awaddr,
    input  quick_spi_pkg::axi_len_t      awlen,
    input  logic [1:0]                   awburst,
    input  logic                         awvalid,
    output logic                         awready,
    input  quick_spi_pkg::axi_data_t     wdata,
    input  quick_spi_pkg::axi_strb_t     wstrb,
    input  logic                         wlast,
    input  logic                         wvalid,
    output logic                         wready,
    output logic [1:0]                   bresp,
    output logic                         bvalid,
    input  logic                         bready,
    input  quick_spi_pkg::axi_addr_t     araddr,
    input  quick_spi_pkg::axi_len_t      arlen,
    input  logic [1:0]                   arburst,
    input  logic                         arvalid,
    output logic                         arready,
    output quick_spi_pkg::axi_data_t     rdata,
    output logic [1:0]                   rresp,
    output logic                         rlast,
    output logic                         rvalid,
    input  logic                         rready,
    output logic                         mosi,
    input  logic                         miso,
    output logic                         sclk,
    output logic [`QSPI_NUM_SLAVES-1:0]  ss_n,
    output logic                         interrupt
);
    import quick_spi_pkg::*;

    // Bus side to memory.
    logic           write_busy;
    logic           read_busy;
    logic           mem_we;
    mem_word_addr_t mem_waddr;
    axi_data_t      mem_wdata;
    axi_strb_t      mem_wstrb;
    mem_word_addr_t mem_raddr;
    axi_data_t      mem_rdata;

    // Memory to engine.
    mem_byte_addr_t eng_byte_addr;
    logic [7:0]     eng_byte;
    logic           rx_we;
    mem_byte_addr_t rx_byte_addr;
    logic [2:0]     rx_bit;
    logic           rx_value;
    logic           done;
    logic           cpol;
    logic           cpha;
    logic           start;
    logic           burst;
    logic           read_en;
    slave_sel_t     slave_idx;
    bit_count_t     out_elem_bits;
    bit_count_t     num_out_elems;
    bit_count_t     in_elem_bits;

    axi_write_slave u_axi_write_slave (.*);

    axi_read_slave u_axi_read_slave (.*);

    spi_buffer_ram u_spi_buffer_ram (.*);

    spi_transfer_engine u_spi_transfer_engine (.*);

endmodule

// File: design/spi_transfer_engine.sv
`timescale 1ns/1ps
`include "quick_spi_config.svh"

module spi_transfer_engine (
    input  logic                           s_axi_aclk,
    input  logic                           s_axi_aresetn,
    input  logic                           cpol,
    input  logic                           cpha,
    input  logic                           start,
    input  logic                           burst,
    input  logic                           read_en,
    input  quick_spi_pkg::slave_sel_t      slave_idx,
    input  quick_spi_pkg::bit_count_t      out_elem_bits,
    input  quick_spi_pkg::bit_count_t      num_out_elems,
    input  quick_spi_pkg::bit_count_t      in_elem_bits,
    input  logic                           write_busy,
    output quick_spi_pkg::mem_byte_addr_t  eng_byte_addr,
    input  logic [7:0]                     eng_byte,
    output logic                           rx_we,
    output quick_spi_pkg::mem_byte_addr_t  rx_byte_addr,
    output logic [2:0]                     rx_bit,
    output logic                           rx_value,
    output logic                           done,
    input  logic                           miso,
    output logic                           mosi,
    output logic                           sclk,
    output logic [`QSPI_NUM_SLAVES-1:0]    ss_n,
    output logic                           interrupt
);
    import quick_spi_pkg::*;

    engine_state_t state;
    logic          ph;
    bit_count_t    slot_cnt;
    bit_count_t    elem_cnt;
    bit_count_t    out_pos;
    bit_count_t    in_pos;
    logic          slot_end;
    logic          out_done;
    logic          in_done;
    logic          last_elem;

    // A bit slot is two toggles; the second one has ph opposite to CPHA.
    assign slot_end = (ph != cpha);
    assign out_done = slot_end && (slot_cnt == out_elem_bits - 16'd1);
    assign in_done = slot_end && (slot_cnt == in_elem_bits - 16'd1);
    assign last_elem = !burst || (elem_cnt == num_out_elems - 16'd1);

    // Bit positions run on across elements.
    assign eng_byte_addr = mem_byte_addr_t'(`QSPI_WBUF_START) + mem_byte_addr_t'(out_pos[15:3]);
    assign rx_byte_addr = mem_byte_addr_t'(`QSPI_RBUF_START) + mem_byte_addr_t'(in_pos[15:3]);
    assign rx_bit = in_pos[2:0];
    assign rx_value = miso;
    assign rx_we = (state == SHIFT_IN) && !ph;
    assign done = (state == END_FRAME) && last_elem;

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            state <= IDLE;
            ss_n <= '1;
            sclk <= 1'b0;
            mosi <= 1'b0;
            interrupt <= 1'b0;
            ph <= 1'b0;
            slot_cnt <= '0;
            elem_cnt <= '0;
            out_pos <= '0;
            in_pos <= '0;
        end else begin
            case (state)
                IDLE: begin
                    sclk <= cpol;
                    ph <= cpha;
                    if (start && !write_busy) begin
                        interrupt <= 1'b0;
                        ss_n[slave_idx] <= 1'b0;
                        slot_cnt <= '0;
                        elem_cnt <= '0;
                        out_pos <= '0;
                        in_pos <= '0;
                        state <= SELECT;
                    end
                end
                SELECT: begin
                    // Mode 0 and 2 put the first bit out before any edge.
                    if (!cpha) begin
                        mosi <= eng_byte[out_pos[2:0]];
                        out_pos <= out_pos + 16'd1;
                    end
                    state <= SHIFT_OUT;
                end
                SHIFT_OUT: begin
                    sclk <= ~sclk;
                    ph <= ~ph;
                    if (out_done) begin
                        slot_cnt <= '0;
                        mosi <= 1'b0;
                        if (read_en) begin
                            state <= SHIFT_IN;
                        end else begin
                            ss_n <= '1;
                            state <= END_FRAME;
                        end
                    end else begin
                        if (slot_end) begin
                            slot_cnt <= slot_cnt + 16'd1;
                        end
                        if (ph) begin
                            mosi <= eng_byte[out_pos[2:0]];
                            out_pos <= out_pos + 16'd1;
                        end
                    end
                end
                SHIFT_IN: begin
                    sclk <= ~sclk;
                    ph <= ~ph;
                    if (!ph) begin
                        in_pos <= in_pos + 16'd1;
                    end
                    if (in_done) begin
                        slot_cnt <= '0;
                        ss_n <= '1;
                        state <= END_FRAME;
                    end else if (slot_end) begin
                        slot_cnt <= slot_cnt + 16'd1;
                    end
                end
                END_FRAME: begin
                    sclk <= cpol;
                    ph <= cpha;
                    elem_cnt <= elem_cnt + 16'd1;
                    if (last_elem) begin
                        interrupt <= 1'b1;
                        state <= IDLE;
                    end else begin
                        ss_n[slave_idx] <= 1'b0;
                        state <= SELECT;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: design/spi_buffer_ram.sv
`timescale 1ns/1ps
`include "quick_spi_config.svh"

module spi_buffer_ram (
    input  logic                           s_axi_aclk,
    input  logic                           s_axi_aresetn,
    input  logic                           mem_we,
    input  quick_spi_pkg::mem_word_addr_t  mem_waddr,
    input  quick_spi_pkg::axi_data_t       mem_wdata,
    input  quick_spi_pkg::axi_strb_t       mem_wstrb,
    input  quick_spi_pkg::mem_word_addr_t  mem_raddr,
    output quick_spi_pkg::axi_data_t       mem_rdata,
    input  quick_spi_pkg::mem_byte_addr_t  eng_byte_addr,
    output logic [7:0]                     eng_byte,
    input  logic                           rx_we,
    input  quick_spi_pkg::mem_byte_addr_t  rx_byte_addr,
    input  logic [2:0]                     rx_bit,
    input  logic                           rx_value,
    input  logic                           done,
    output logic                           cpol,
    output logic                           cpha,
    output logic                           start,
    output logic                           burst,
    output logic                           read_en,
    output quick_spi_pkg::slave_sel_t      slave_idx,
    output quick_spi_pkg::bit_count_t      out_elem_bits,
    output quick_spi_pkg::bit_count_t      num_out_elems,
    output quick_spi_pkg::bit_count_t      in_elem_bits
);
    import quick_spi_pkg::*;

    logic [7:0] mem [`QSPI_MEM_BYTES];

    always_ff @(posedge s_axi_aclk) begin
        for (int b = 0; b < `QSPI_DATA_W / 8; b++) begin
            if (mem_we && mem_wstrb[b]) begin
                mem[{mem_waddr, 2'(b)}] <= mem_wdata[8*b +: 8];
            end
        end
        if (rx_we) begin
            mem[rx_byte_addr][rx_bit] <= rx_value;
        end
        // Control byte comes up cleared so no transfer starts.
        if (!s_axi_aresetn) begin
            mem[0] <= 8'h00;
        end else if (done) begin
            mem[0][2] <= 1'b0;
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        mem_rdata <= {mem[{mem_raddr, 2'd3}], mem[{mem_raddr, 2'd2}],
                      mem[{mem_raddr, 2'd1}], mem[{mem_raddr, 2'd0}]};
    end

    assign eng_byte = mem[eng_byte_addr];

    assign cpol = mem[0][0];
    assign cpha = mem[0][1];
    assign start = mem[0][2];
    assign burst = mem[0][3];
    assign read_en = mem[0][4];
    assign slave_idx = slave_sel_t'(mem[1]);
    assign out_elem_bits = {mem[3], mem[2]};
    assign num_out_elems = {mem[5], mem[4]};
    assign in_elem_bits = {mem[7], mem[6]};

endmodule

// File: design/axi_read_slave.sv
`timescale 1ns/1ps
`include "quick_spi_config.svh"

module axi_read_slave (
    input  logic                           s_axi_aclk,
    input  logic                           s_axi_aresetn,
    input  quick_spi_pkg::axi_addr_t       araddr,
    input  quick_spi_pkg::axi_len_t        arlen,
    input  logic [1:0]                     arburst,
    input  logic                           arvalid,
    output logic                           arready,
    output quick_spi_pkg::axi_data_t       rdata,
    output logic [1:0]                     rresp,
    output logic                           rlast,
    output logic                           rvalid,
    input  logic                           rready,
    input  logic                           write_busy,
    output logic                           read_busy,
    output quick_spi_pkg::mem_word_addr_t  mem_raddr,
    input  quick_spi_pkg::axi_data_t       mem_rdata
);
    import quick_spi_pkg::*;

    axi_addr_t  addr_q;
    axi_len_t   len_q;
    axi_len_t   beat_cnt;
    logic [1:0] burst_q;
    logic       ar_accept;
    logic       r_beat;

    assign ar_accept = !arready && arvalid && !read_busy && !write_busy;
    assign r_beat = rvalid && rready;

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            arready <= 1'b0;
            read_busy <= 1'b0;
            rvalid <= 1'b0;
            rlast <= 1'b0;
        end else begin
            arready <= ar_accept;
            if (ar_accept) begin
                read_busy <= 1'b1;
            end else if (r_beat && rlast) begin
                read_busy <= 1'b0;
            end
            // Word is registered by the RAM while rvalid is low.
            if (read_busy && !rvalid) begin
                rvalid <= 1'b1;
                rlast <= (beat_cnt == len_q);
            end else if (r_beat) begin
                rvalid <= 1'b0;
                rlast <= 1'b0;
            end
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (ar_accept) begin
            addr_q <= araddr;
            len_q <= arlen;
            burst_q <= arburst;
            beat_cnt <= '0;
        end else if (r_beat) begin
            beat_cnt <= beat_cnt + 8'd1;
            if (burst_q == `QSPI_BURST_INCR) begin
                addr_q[`QSPI_ADDR_W-1:2] <= addr_q[`QSPI_ADDR_W-1:2] + 1'b1;
            end
        end
    end

    assign mem_raddr = mem_word_addr_t'(addr_q[`QSPI_ADDR_W-1:2]);
    assign rdata = rvalid ? mem_rdata : '0;
    assign rresp = `QSPI_RESP_OKAY;

endmodule

// File: design/axi_write_slave.sv
`timescale 1ns/1ps
`include "quick_spi_config.svh"

module axi_write_slave (
    input  logic                           s_axi_aclk,
    input  logic                           s_axi_aresetn,
    input  quick_spi_pkg::axi_addr_t       awaddr,
    input  quick_spi_pkg::axi_len_t        awlen,
    input  logic [1:0]                     awburst,
    input  logic                           awvalid,
    output logic                           awready,
    input  quick_spi_pkg::axi_data_t       wdata,
    input  quick_spi_pkg::axi_strb_t       wstrb,
    input  logic                           wlast,
    input  logic                           wvalid,
    output logic                           wready,
    output logic [1:0]                     bresp,
    output logic                           bvalid,
    input  logic                           bready,
    input  logic                           read_busy,
    output logic                           write_busy,
    output logic                           mem_we,
    output quick_spi_pkg::mem_word_addr_t  mem_waddr,
    output quick_spi_pkg::axi_data_t       mem_wdata,
    output quick_spi_pkg::axi_strb_t       mem_wstrb
);
    import quick_spi_pkg::*;

    axi_addr_t  addr_q;
    axi_len_t   len_q;
    axi_len_t   beat_cnt;
    logic [1:0] burst_q;
    logic       aw_accept;
    logic       w_beat;

    assign aw_accept = !awready && awvalid && !write_busy && !read_busy;
    assign w_beat = wready && wvalid;

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            awready <= 1'b0;
            write_busy <= 1'b0;
            wready <= 1'b0;
            bvalid <= 1'b0;
        end else begin
            awready <= aw_accept;
            if (aw_accept) begin
                write_busy <= 1'b1;
            end else if (w_beat && wlast) begin
                write_busy <= 1'b0;
            end
            if (!wready && wvalid && write_busy) begin
                wready <= 1'b1;
            end else if (w_beat && wlast) begin
                wready <= 1'b0;
            end
            // Response holds until taken.
            if (w_beat && wlast) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (aw_accept) begin
            addr_q <= awaddr;
            len_q <= awlen;
            burst_q <= awburst;
            beat_cnt <= '0;
        end else if (w_beat) begin
            beat_cnt <= beat_cnt + 8'd1;
            if (burst_q == `QSPI_BURST_INCR) begin
                addr_q[`QSPI_ADDR_W-1:2] <= addr_q[`QSPI_ADDR_W-1:2] + 1'b1;
            end
        end
    end

    // Beats past the announced length are dropped.
    assign mem_we = w_beat && (beat_cnt <= len_q);
    assign mem_waddr = mem_word_addr_t'(addr_q[`QSPI_ADDR_W-1:2]);
    assign mem_wdata = wdata;
    assign mem_wstrb = wstrb;
    assign bresp = `QSPI_RESP_OKAY;

endmodule

// File: design/quick_spi_pkg.sv
`include "quick_spi_config.svh"

package quick_spi_pkg;

    typedef logic [`QSPI_ADDR_W-1:0] axi_addr_t;
    typedef logic [`QSPI_DATA_W-1:0] axi_data_t;
    typedef logic [`QSPI_DATA_W/8-1:0] axi_strb_t;
    typedef logic [7:0] axi_len_t;

    // Word and byte indexes into the buffer memory.
    typedef logic [$clog2(`QSPI_MEM_BYTES/(`QSPI_DATA_W/8))-1:0] mem_word_addr_t;
    typedef logic [$clog2(`QSPI_MEM_BYTES)-1:0] mem_byte_addr_t;

    typedef logic [15:0] bit_count_t;
    typedef logic [$clog2(`QSPI_NUM_SLAVES)-1:0] slave_sel_t;

    typedef enum logic [2:0] {
        IDLE,
        SELECT,
        SHIFT_OUT,
        SHIFT_IN,
        END_FRAME
    } engine_state_t;

endpackage

// File: design/quick_spi_config.svh
`ifndef QUICK_SPI_CONFIG_SVH
`define QUICK_SPI_CONFIG_SVH

// AXI port widths.
`define QSPI_DATA_W 32
`define QSPI_ADDR_W 8

// Register and buffer memory.
`define QSPI_MEM_BYTES 64
`define QSPI_NUM_SLAVES 2
`define QSPI_WBUF_START 12
`define QSPI_RBUF_START 38

// AXI burst and response encodings.
`define QSPI_BURST_INCR 2'b01
`define QSPI_RESP_OKAY 2'b00

`endif
